// File: bench/fifo_stimulus.txt
# One phase per line, expected credits = min(initial,8) - min(withhold,8), floored at 0
# initial withhold sender_reset_cycles stall_cycles push_count pop_ready_duty expected_credits
8 0 3 0 8 0 8
8 0 2 0 20 100 8
6 2 4 5 12 60 4
15 3 2 3 10 30 5
3 5 2 0 0 50 0
4 1 3 6 16 80 3
8 0 2 2 8 0 8
8 2 2 0 1 100 6

// File: sources.f
design/fifo_pkg.sv
design/fifo_ram_if.sv
design/fifo_credit_regs.sv
design/fifo_push_ctrl_credit.sv
design/fifo_pop_ctrl.sv
design/fifo_flop_ram.sv
design/fifo_ctrl_1r1w_push_credit.sv
bench/fifo_assertions.sv
bench/fifo_tb.sv

// File: Bender.yml
package:
  name: fifo_ctrl_1r1w_push_credit

sources:
  - files:
      - design/fifo_pkg.sv
      - design/fifo_ram_if.sv
      - design/fifo_credit_regs.sv
      - design/fifo_push_ctrl_credit.sv
      - design/fifo_pop_ctrl.sv
      - design/fifo_flop_ram.sv
      - design/fifo_ctrl_1r1w_push_credit.sv
  - target: test
    files:
      - bench/fifo_assertions.sv
      - bench/fifo_tb.sv

// File: bench/fifo_tb.sv
/*
 * Stimulus and expected credit totals come from bench/fifo_stimulus.txt, relative to the root.
 * Every phase starts from an empty FIFO and first puts the sender back into reset.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_tb;

  // Upper bound in cycles for any single wait
  localparam int LIMIT = 300;

  logic clk, rst, reg_wr, reg_sel;
  logic [fifo_pkg::CREDIT_W-1:0] reg_wdata, credit_count, credit_available;
  logic push_sender_in_reset, push_receiver_in_reset, push_credit_stall, push_credit;
  logic push_valid, pop_ready, pop_valid, full, empty;
  logic [fifo_pkg::WIDTH-1:0] push_data, pop_data;
  logic [fifo_pkg::COUNT_W-1:0] slots, items;

  // Reference model of the FIFO contents, oldest first
  logic [fifo_pkg::WIDTH-1:0] model_q[$];
  int errors = 0;
  int checks = 0;
  // Credits the sender holds, and pulses seen since the sender last left reset
  int credits_held = 0;
  int phase_credits = 0;
  int to_push = 0;
  int duty = 0;
  int stall_left = 0;
  int step_no = 0;
  // Step of a push into an empty FIFO, probed for the two-edge latency
  int lat_step = -10;
  logic [fifo_pkg::WIDTH-1:0] lat_word;

  fifo_ctrl_1r1w_push_credit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // --------------------
  // One falling edge: observe outputs, then drive the next inputs
  // --------------------
  task automatic advance_cycle();
    @(negedge clk);
    step_no++;
    // Stall and sender reset still hold the values that governed this pulse
    if (push_credit && (push_credit_stall || push_sender_in_reset)) begin
      report_error("credit pulse while stalled or while the sender was in reset");
    end
    credits_held += int'(push_credit);
    phase_credits += int'(push_credit);
    if (step_no == lat_step + 1) check("pop_valid", pop_valid, 0);
    if (step_no == lat_step + 2) begin
      check("pop_valid", pop_valid, 1);
      check("pop_data", pop_data, lat_word);
    end
    push_credit_stall = (stall_left > 0);
    if (stall_left > 0) stall_left--;
    pop_ready = (int'($urandom % 100) < duty);
    // The beat lands at the next rising edge, so the word is taken from the model now
    if (pop_valid && pop_ready) begin
      if (model_q.size() == 0) report_error("pop beat while the model holds nothing");
      else check("pop_data", pop_data, model_q.pop_front());
    end
    push_valid = 1'b0;
    // The sender spends one held credit per push
    if (to_push > 0 && credits_held > 0 && !push_sender_in_reset) begin
      push_data = fifo_pkg::WIDTH'($urandom);
      if (model_q.size() == 0 && !pop_valid && items == 0 && duty == 100) begin
        lat_step = step_no;
        lat_word = push_data;
      end
      push_valid = 1'b1;
      model_q.push_back(push_data);
      credits_held--;
      to_push--;
    end
  endtask

  task automatic run_phase(input int init_v, input int wh_v, input int sir_len,
                           input int stall_len, input int n_push, input int duty_v,
                           input int exp_v);
    int n;
    int idle;
    int init_c;
    // A written initial value saturates at the depth
    init_c = (init_v > fifo_pkg::DEPTH) ? fifo_pkg::DEPTH : init_v;
    // Sender reset goes up before the writes so new values cannot release stray credits
    duty = 0;
    push_sender_in_reset = 1'b1;
    credits_held = 0;
    reg_wr = 1'b1;
    reg_sel = fifo_pkg::REG_SEL_INITIAL;
    reg_wdata = fifo_pkg::CREDIT_W'(init_v);
    advance_cycle();
    reg_sel = fifo_pkg::REG_SEL_WITHHOLD;
    reg_wdata = fifo_pkg::CREDIT_W'(wh_v);
    advance_cycle();
    reg_wr = 1'b0;
    repeat (sir_len) advance_cycle();
    // The counter has reloaded the initial value and nothing has been granted yet
    check("credit_count", credit_count, init_c);
    check("credit_available", credit_available, exp_v);
    push_sender_in_reset = 1'b0;
    push_credit_stall = (stall_len > 0);
    stall_left = (stall_len > 0) ? stall_len - 1 : 0;
    phase_credits = 0;
    // Count the initial grant until the stall is over and pulses have stopped
    n = 0;
    idle = 0;
    while ((push_credit_stall || idle < 4) && n < LIMIT) begin
      advance_cycle();
      n++;
      idle = (push_credit || push_credit_stall) ? 0 : idle + 1;
    end
    if (n >= LIMIT) report_error("timeout waiting for the initial credits to settle");
    check("credit pulses", phase_credits, exp_v);
    check("credit_available", credit_available, 0);
    check("credit_count", credit_count, init_c - exp_v);
    duty = duty_v;
    to_push = n_push;
    n = 0;
    while (to_push > 0 && n < LIMIT) begin
      advance_cycle();
      n++;
    end
    if (to_push > 0) report_error("timeout waiting for credits to push every word");
    // Without pops the FIFO holds every pushed word
    if (duty_v == 0) begin
      advance_cycle();
      check("items", items, n_push);
      check("slots", slots, fifo_pkg::DEPTH - n_push);
      check("full", full, n_push == fifo_pkg::DEPTH);
      duty = 100;
    end
    n = 0;
    while ((model_q.size() > 0 || phase_credits < exp_v + n_push) && n < LIMIT) begin
      advance_cycle();
      n++;
    end
    if (n >= LIMIT) report_error("timeout waiting for the FIFO to drain and credits to return");
    repeat (3) advance_cycle();
    // Each pop beat gives back exactly one credit pulse
    check("credit pulses", phase_credits, exp_v + n_push);
    check("credit_count", credit_count, init_c - exp_v);
    check("empty", empty, 1);
    check("items", items, 0);
    check("slots", slots, fifo_pkg::DEPTH);
    check("pop_valid", pop_valid, 0);
    duty = 0;
  endtask

  initial begin
    int fd;
    int v[7];
    string line;
    void'($urandom(32'h22a9));
    rst = 1'b1;
    reg_wr = 1'b0;
    reg_sel = 1'b0;
    reg_wdata = '0;
    push_sender_in_reset = 1'b1;
    push_credit_stall = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check("push_receiver_in_reset", push_receiver_in_reset, 1);
    rst = 1'b0;
    check("empty", empty, 1);
    check("full", full, 0);
    check("items", items, 0);
    check("slots", slots, fifo_pkg::DEPTH);
    check("pop_valid", pop_valid, 0);
    check("push_credit", push_credit, 0);
    advance_cycle();
    check("push_receiver_in_reset", push_receiver_in_reset, 0);
    fd = $fopen("bench/fifo_stimulus.txt", "r");
    if (fd == 0) begin
      report_error("cannot open bench/fifo_stimulus.txt");
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5],
                    v[6]) != 7) begin
          report_error("stimulus line does not hold seven numbers");
          continue;
        end
        run_phase(v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
      end
      $fclose(fd);
    end
    errors += u_dut.u_assertions.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : fifo_tb

`default_nettype wire

// File: bench/fifo_assertions.sv
/*
 * Bound into the FIFO top level, where the ports of both controllers are visible.
 * Credit bookkeeping restarts whenever the sender is in reset.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_assertions (
  input logic                         clk,
  input logic                         rst,
  input logic                         push_sender_in_reset,
  input logic                         push_credit,
  input logic                         push_valid,
  input logic                         pop_valid,
  input logic                         pop_ready,
  input logic [fifo_pkg::WIDTH-1:0]   pop_data,
  input logic [fifo_pkg::COUNT_W-1:0] items,
  input logic [fifo_pkg::COUNT_W-1:0] slots
);

  // Credits the sender has received and not yet spent
  int held;
  // Failures so far, read by the testbench at the end of the run
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (rst || push_sender_in_reset) begin
      held <= 0;
    end else begin
      held <= held + int'(push_credit) - int'(push_valid);
    end
  end

  // A pulse sampled at the same edge already counts as held
  push_needs_credit: assert property (@(posedge clk) disable iff (rst)
    push_valid |-> (held + int'(push_credit)) > 0)
    else begin
      $error("push without a credit held");
      fail_count++;
    end

  pop_output_steady: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else begin
      $error("pop output changed under back-pressure");
      fail_count++;
    end

  occupancy_bound: assert property (@(posedge clk) disable iff (rst)
    (int'(items) + int'(slots)) <= fifo_pkg::DEPTH)
    else begin
      $error("items plus slots exceeds the depth");
      fail_count++;
    end

endmodule : fifo_assertions

bind fifo_ctrl_1r1w_push_credit fifo_assertions u_assertions (.*);

`default_nettype wire

// File: design/fifo_ctrl_1r1w_push_credit.sv
/*
 * Credit/valid push, registered ready/valid pop, flop RAM inside.
 * Push to pop takes two edges; a popped slot returns as a credit two edges after the pop.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_ctrl_1r1w_push_credit (
  input  logic                          clk,
  input  logic                          rst,

  // Host configuration
  input  logic                          reg_wr,
  input  logic                          reg_sel,
  input  logic [fifo_pkg::CREDIT_W-1:0] reg_wdata,

  // Push side
  input  logic                          push_sender_in_reset,
  output logic                          push_receiver_in_reset,
  input  logic                          push_credit_stall,
  output logic                          push_credit,
  input  logic                          push_valid,
  input  logic [fifo_pkg::WIDTH-1:0]    push_data,

  // Pop side
  input  logic                          pop_ready,
  output logic                          pop_valid,
  output logic [fifo_pkg::WIDTH-1:0]    pop_data,

  // Status
  output logic                          full,
  output logic [fifo_pkg::COUNT_W-1:0]  slots,
  output logic                          empty,
  output logic [fifo_pkg::COUNT_W-1:0]  items,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_count,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_available
);

  logic [fifo_pkg::CREDIT_W-1:0] credit_initial;
  logic [fifo_pkg::CREDIT_W-1:0] credit_withhold;
  // Beats cross between the controllers so each side can keep its own count
  logic                          push_beat;
  logic                          pop_beat;

  fifo_ram_if ram_bus ();

  // --------------------
  // Configuration
  // --------------------

  fifo_credit_regs u_credit_regs (
    .clk             (clk),
    .rst             (rst),
    .reg_wr          (reg_wr),
    .reg_sel         (reg_sel),
    .reg_wdata       (reg_wdata),
    .credit_initial  (credit_initial),
    .credit_withhold (credit_withhold)
  );

  // --------------------
  // Controllers and storage
  // --------------------

  fifo_push_ctrl_credit u_push_ctrl (
    .clk                    (clk),
    .rst                    (rst),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_receiver_in_reset (push_receiver_in_reset),
    .push_credit_stall      (push_credit_stall),
    .push_credit            (push_credit),
    .push_valid             (push_valid),
    .push_data              (push_data),
    .credit_initial         (credit_initial),
    .credit_withhold        (credit_withhold),
    .credit_count           (credit_count),
    .credit_available       (credit_available),
    .full                   (full),
    .slots                  (slots),
    .ram                    (ram_bus.wr),
    .push_beat              (push_beat),
    .pop_beat               (pop_beat)
  );

  fifo_pop_ctrl u_pop_ctrl (
    .clk       (clk),
    .rst       (rst),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .empty     (empty),
    .items     (items),
    .ram       (ram_bus.rd),
    .push_beat (push_beat),
    .pop_beat  (pop_beat)
  );

  fifo_flop_ram u_ram (
    .clk (clk),
    .ram (ram_bus.mem)
  );

endmodule : fifo_ctrl_1r1w_push_credit

`default_nettype wire

// File: design/fifo_flop_ram.sv
/*
 * Flop storage with one write and one combinational read port.
 * Contents are undefined after reset; the controllers never read an unwritten entry.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_flop_ram (
  input logic     clk,
  fifo_ram_if.mem ram
);

  logic [fifo_pkg::WIDTH-1:0] mem [fifo_pkg::DEPTH];

  // The word is stored at the edge where wr_valid is high
  always_ff @(posedge clk) begin
    if (ram.wr_valid) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Zero-latency read, so the pop stage sees the entry in the same cycle
  assign ram.rd_data = mem[ram.rd_addr];

endmodule : fifo_flop_ram

`default_nettype wire

// File: design/fifo_pop_ctrl.sv
/*
 * pop_valid and pop_data always come from flops; there is no push-to-pop bypass.
 * Assumes a RAM read latency of zero and a written word readable one edge later.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_pop_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pop_ready,
  output logic                         pop_valid,
  output logic [fifo_pkg::WIDTH-1:0]   pop_data,
  output logic                         empty,
  output logic [fifo_pkg::COUNT_W-1:0] items,
  fifo_ram_if.rd                       ram,
  input  logic                         push_beat,
  output logic                         pop_beat
);

  logic [fifo_pkg::ADDR_W-1:0]  rd_ptr;
  // Entries still in RAM, not counting the one held in the output stage
  logic [fifo_pkg::COUNT_W-1:0] ram_items;
  // The output stage takes the oldest RAM entry at the next edge
  logic                         stage_load;

  // --------------------
  // Occupancy
  // --------------------

  assign pop_beat = pop_valid && pop_ready;

  // items covers RAM and the output stage together
  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else begin
      items <= items + fifo_pkg::COUNT_W'(push_beat) - fifo_pkg::COUNT_W'(pop_beat);
    end
  end

  assign empty = (items == '0);

  // A valid output stage holds exactly one of the counted items
  assign ram_items = items - fifo_pkg::COUNT_W'(pop_valid);

  // --------------------
  // Read side and output stage
  // --------------------

  // Load when the stage is free or draining this cycle and RAM has something waiting
  assign stage_load = (ram_items != '0) && (!pop_valid || pop_ready);

  // The read pointer always addresses the oldest entry still in RAM
  assign ram.rd_addr = rd_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (stage_load) begin
      if (rd_ptr == fifo_pkg::ADDR_W'(fifo_pkg::DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Valid stays up through back-pressure and drops only when popped with nothing behind
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (stage_load) begin
      pop_valid <= 1'b1;
    end else if (pop_beat) begin
      pop_valid <= 1'b0;
    end
  end

  // Data changes only on a load, so it holds steady while the sink is not ready
  always_ff @(posedge clk) begin
    if (stage_load) begin
      pop_data <= ram.rd_data;
    end
  end

endmodule : fifo_pop_ctrl

`default_nettype wire

// File: design/fifo_push_ctrl_credit.sv
/*
 * The sender must only raise push_valid while it holds a credit; pushes are not checked here.
 * push_credit comes straight from a flop and is held low while the sender is in reset.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_push_ctrl_credit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          push_sender_in_reset,
  output logic                          push_receiver_in_reset,
  input  logic                          push_credit_stall,
  output logic                          push_credit,
  input  logic                          push_valid,
  input  logic [fifo_pkg::WIDTH-1:0]    push_data,
  input  logic [fifo_pkg::CREDIT_W-1:0] credit_initial,
  input  logic [fifo_pkg::CREDIT_W-1:0] credit_withhold,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_count,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_available,
  output logic                          full,
  output logic [fifo_pkg::COUNT_W-1:0]  slots,
  fifo_ram_if.wr                        ram,
  output logic                          push_beat,
  input  logic                          pop_beat
);

  logic [fifo_pkg::ADDR_W-1:0] wr_ptr;
  // High in the cycle before push_credit pulses
  logic                        credit_grant;

  // --------------------
  // Push path
  // --------------------

  // Every valid is a beat because the sender spent a credit to send it
  assign push_beat = push_valid;

  // The word goes straight into RAM and is stored at the edge that accepts it
  assign ram.wr_valid = push_beat;
  assign ram.wr_addr  = wr_ptr;
  assign ram.wr_data  = push_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_beat) begin
      if (wr_ptr == fifo_pkg::ADDR_W'(fifo_pkg::DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // A push takes a slot and a pop gives one back; both together cancel
  always_ff @(posedge clk) begin
    if (rst) begin
      slots <= fifo_pkg::COUNT_W'(fifo_pkg::DEPTH);
    end else begin
      slots <= slots + fifo_pkg::COUNT_W'(pop_beat) - fifo_pkg::COUNT_W'(push_beat);
    end
  end

  assign full = (slots == '0);

  // Tells the sender that this side is still in reset, one cycle behind rst
  always_ff @(posedge clk) begin
    push_receiver_in_reset <= rst;
  end

  // --------------------
  // Credit counter
  // --------------------

  // Credits above the withhold level may be released, never fewer than zero
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // A credit is released when one is available and the sender is not stalling us
  assign credit_grant = !push_sender_in_reset && !push_credit_stall &&
                        (credit_available != '0);

  // The count drops at the same edge that raises push_credit, so one grant is one pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= fifo_pkg::CREDIT_INITIAL_RST;
    end else if (push_sender_in_reset) begin
      // The sender forgets its credits in reset, so start again from the configured value
      credit_count <= credit_initial;
    end else begin
      credit_count <= credit_count + fifo_pkg::CREDIT_W'(pop_beat)
                    - fifo_pkg::CREDIT_W'(credit_grant);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= credit_grant;
    end
  end

endmodule : fifo_push_ctrl_credit

`default_nettype wire

// File: design/fifo_credit_regs.sv
/*
 * Written values above DEPTH are clamped to DEPTH.
 * A write lands at the next edge; there is no read-back path.
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_credit_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          reg_wr,
  input  logic                          reg_sel,
  input  logic [fifo_pkg::CREDIT_W-1:0] reg_wdata,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_initial,
  output logic [fifo_pkg::CREDIT_W-1:0] credit_withhold
);

  logic [fifo_pkg::CREDIT_W-1:0] wdata_clamped;

  // The FIFO can never owe more than DEPTH credits, so larger values saturate
  always_comb begin
    if (reg_wdata > fifo_pkg::CREDIT_W'(fifo_pkg::DEPTH)) begin
      wdata_clamped = fifo_pkg::CREDIT_W'(fifo_pkg::DEPTH);
    end else begin
      wdata_clamped = reg_wdata;
    end
  end

  // --------------------
  // Configuration flops
  // --------------------

  // Credits handed out when the sender comes out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_initial <= fifo_pkg::CREDIT_INITIAL_RST;
    end else if (reg_wr && (reg_sel == fifo_pkg::REG_SEL_INITIAL)) begin
      credit_initial <= wdata_clamped;
    end
  end

  // Credits kept back from the sender; zero means none are withheld
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_withhold <= '0;
    end else if (reg_wr && (reg_sel == fifo_pkg::REG_SEL_WITHHOLD)) begin
      credit_withhold <= wdata_clamped;
    end
  end

endmodule : fifo_credit_regs

`default_nettype wire

// File: design/fifo_ram_if.sv
/*
 * Write and read ports between the FIFO controllers and the flop RAM.
 * The write takes effect at the next edge and the read has zero latency.
 */
`timescale 1ns/100ps
`default_nettype none

interface fifo_ram_if;

  // Write port, owned by the push controller
  logic                         wr_valid;
  logic [fifo_pkg::ADDR_W-1:0]  wr_addr;
  logic [fifo_pkg::WIDTH-1:0]   wr_data;

  // Read port, address from the pop controller and data from the RAM
  logic [fifo_pkg::ADDR_W-1:0]  rd_addr;
  logic [fifo_pkg::WIDTH-1:0]   rd_data;

  // Push controller side
  modport wr (
    output wr_valid,
    output wr_addr,
    output wr_data
  );

  // Pop controller side
  modport rd (
    output rd_addr,
    input  rd_data
  );

  // Storage side
  modport mem (
    input  wr_valid,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface : fifo_ram_if

`default_nettype wire

// File: design/fifo_pkg.sv
/*
 * Depth and width are fixed here; DEPTH must stay a power of two for the pointer wrap.
 * Credit values are in entries and never go above DEPTH.
 */
`default_nettype none

package fifo_pkg;

  // --------------------
  // Storage geometry
  // --------------------

  // Number of entries in the flop RAM
  localparam int DEPTH = 8;
  // Bits per entry
  localparam int WIDTH = 16;
  // RAM address width, 3 for eight entries
  localparam int ADDR_W = $clog2(DEPTH);
  // Counts run from 0 to DEPTH inclusive, so one extra bit is needed
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // --------------------
  // Credit configuration
  // --------------------

  // The credit counter holds up to DEPTH credits
  localparam int CREDIT_W = $clog2(DEPTH + 1);

  // Host register selects
  localparam logic REG_SEL_INITIAL = 1'b0;
  localparam logic REG_SEL_WITHHOLD = 1'b1;

  // After reset the sender is offered the whole FIFO
  localparam logic [CREDIT_W-1:0] CREDIT_INITIAL_RST = CREDIT_W'(DEPTH);

endpackage : fifo_pkg

`default_nettype wire
